//--- rtl/bringup_params.svh
// macros for the uart divisor, the first character and the colour steps

`ifndef BRINGUP_PARAMS_SVH
`define BRINGUP_PARAMS_SVH

// ----------------------------------------------------------------------------
//	serial port
// ----------------------------------------------------------------------------

// clocks per bit, 27 MHz / 115200 baud
`define BRINGUP_UART_DIV	234

// 'A', the switch nibble is added on top
`define BRINGUP_CHAR_BASE	8'h41

// ----------------------------------------------------------------------------
//	colour ramp
// ----------------------------------------------------------------------------

// per-clock increments, wrap at 32
`define BRINGUP_STEP_R		5'd1
`define BRINGUP_STEP_G		5'd3
`define BRINGUP_STEP_B		5'd5

`endif

//--- rtl/bringup_pkg.sv
// shared vector typedefs and the sequencer state enum for the bring-up test

package bringup_pkg;

	// ------------------------------------------------------------------------
	//	pin groups
	// ------------------------------------------------------------------------

	// one colour channel of the video connector
	typedef logic [4:0] colour_t;

	// msx slot data bus
	typedef logic [7:0] slot_data_t;

	// ------------------------------------------------------------------------
	//	control side
	// ------------------------------------------------------------------------

	// one character for the serial port
	typedef logic [7:0] uart_byte_t;

	// board switches
	// bit 4 freezes the pin exercise, bits 3:0 pick the character
	typedef logic [4:0] dipsw_t;

	// character issue fsm
	typedef enum logic [1:0] {
		seq_idle		= 2'd0,
		seq_issue		= 2'd1,
		seq_wait_busy	= 2'd2
	} seq_state_t;

endpackage

//--- rtl/bringup_sequencer.sv
// switch synchronizer, exercise enable and character issue fsm

`timescale 1ns/1ps

`include "bringup_params.svh"

module bringup_sequencer (
	input	logic					clk27m,
	input	logic					ff_reset_n,
	input	bringup_pkg::dipsw_t	dipsw,
	input	logic					send_busy,
	output	logic					send_req,
	output	bringup_pkg::uart_byte_t	send_data,
	output	logic					exercise_en
);
	bringup_pkg::dipsw_t		ff_sw_meta;
	bringup_pkg::dipsw_t		ff_sw_sync;
	bringup_pkg::seq_state_t	ff_state;
	bringup_pkg::uart_byte_t	ff_send_data;
	logic						ff_busy_seen;

	// ------------------------------------------------------------------------
	//	switch synchronizer
	// ------------------------------------------------------------------------

	// freeze bit comes up set so the datapath stays still while filling
	always_ff @(posedge clk27m) begin
		if (!ff_reset_n) begin
			ff_sw_meta <= 5'b1_0000;
			ff_sw_sync <= 5'b1_0000;
		end
		else begin
			ff_sw_meta <= dipsw;
			ff_sw_sync <= ff_sw_meta;
		end
	end

	// two clocks from pin to enable
	assign exercise_en = ~ff_sw_sync[4];

	// ------------------------------------------------------------------------
	//	character issue
	// ------------------------------------------------------------------------

	always_ff @(posedge clk27m) begin
		if (!ff_reset_n) begin
			ff_state <= bringup_pkg::seq_idle;
			ff_busy_seen <= 1'b0;
		end
		else begin
			case (ff_state)
			bringup_pkg::seq_idle: begin
				ff_busy_seen <= 1'b0;
				if (!send_busy) begin
					ff_state <= bringup_pkg::seq_issue;
				end
			end
			bringup_pkg::seq_issue: begin
				ff_state <= bringup_pkg::seq_wait_busy;
			end
			bringup_pkg::seq_wait_busy: begin
				// busy rises one clock after the request
				if (send_busy) begin
					ff_busy_seen <= 1'b1;
				end
				else if (ff_busy_seen) begin
					ff_state <= bringup_pkg::seq_idle;
				end
			end
			default: begin
				ff_state <= bringup_pkg::seq_idle;
			end
			endcase
		end
	end

	// character latched on the way into issue
	always_ff @(posedge clk27m) begin
		if (ff_state == bringup_pkg::seq_idle) begin
			ff_send_data <= `BRINGUP_CHAR_BASE + {4'd0, ff_sw_sync[3:0]};
		end
	end

	assign send_req = (ff_state == bringup_pkg::seq_issue);
	assign send_data = ff_send_data;

	// handshake with the uart
	a_req_not_busy: assert property (@(posedge clk27m) disable iff (!ff_reset_n)
		send_req |-> !send_busy);
	a_req_single: assert property (@(posedge clk27m) disable iff (!ff_reset_n)
		send_req |=> !send_req);

endmodule

//--- rtl/slot_pin_exerciser.sv
// data bus counter and wait and interrupt toggles for the slot pins

`timescale 1ns/1ps

module slot_pin_exerciser (
	input	logic						clk27m,
	input	logic						ff_reset_n,
	input	logic						exercise_en,
	output	bringup_pkg::slot_data_t	slot_data,
	output	logic						slot_wait,
	output	logic						slot_int
);
	bringup_pkg::slot_data_t	ff_slot_data;
	logic						ff_slot_wait;
	logic						ff_slot_int;

	// ------------------------------------------------------------------------
	//	data bus
	// ------------------------------------------------------------------------

	// binary count, bit n toggles at clk / 2^(n+1)
	// same enable as the video ramp, so low bits track red
	always_ff @(posedge clk27m) begin
		if (!ff_reset_n) begin
			ff_slot_data <= 8'd0;
		end
		else if (exercise_en) begin
			ff_slot_data <= ff_slot_data + 8'd1;
		end
	end

	// ------------------------------------------------------------------------
	//	control lines
	// ------------------------------------------------------------------------

	always_ff @(posedge clk27m) begin
		if (!ff_reset_n) begin
			ff_slot_wait <= 1'b0;
			ff_slot_int <= 1'b0;
		end
		else if (exercise_en) begin
			ff_slot_wait <= ~ff_slot_wait;
			ff_slot_int <= ~ff_slot_int;
		end
	end

	assign slot_data = ff_slot_data;
	assign slot_wait = ff_slot_wait;
	assign slot_int = ff_slot_int;

	// both lines flip together from a common reset
	a_wait_int_equal: assert property (@(posedge clk27m) disable iff (!ff_reset_n)
		ff_slot_wait == ff_slot_int);

endmodule

//--- rtl/tangprimer20k_vdp_cartridge_test.sv
// top level of the cartridge bring-up test, blocks wired to the board pins

`timescale 1ns/1ps

`include "bringup_params.svh"

module tangprimer20k_vdp_cartridge_test (
	input	logic						clk27m,
	input	logic						ff_reset_n,
	input	bringup_pkg::dipsw_t		dipsw,
	// ------------------------------------------------------------------------
	//	msx slot, inputs not decoded in this test
	// ------------------------------------------------------------------------
	input	logic						p_slot_reset_n,
	input	logic						p_slot_sltsl_n,
	input	logic						p_slot_mreq_n,
	input	logic						p_slot_ioreq_n,
	input	logic						p_slot_wr_n,
	input	logic						p_slot_rd_n,
	input	logic						p_slot_m1_n,
	input	logic						p_slot_rfsh_n,
	input	logic [15:0]				p_slot_address,
	output	bringup_pkg::slot_data_t	p_slot_data,
	output	logic						p_slot_data_dir,
	output	logic						p_slot_oe_n,
	output	logic						p_slot_int,
	output	logic						p_slot_wait,
	// ------------------------------------------------------------------------
	//	video connector
	// ------------------------------------------------------------------------
	output	logic						p_video_hs,
	output	logic						p_video_vs,
	output	bringup_pkg::colour_t		p_video_r,
	output	bringup_pkg::colour_t		p_video_g,
	output	bringup_pkg::colour_t		p_video_b,
	// serial debug port
	output	logic						uart_tx
);
	logic						w_exercise_en;
	logic						w_send_req;
	logic						w_send_busy;
	bringup_pkg::uart_byte_t	w_send_data;

	// switches in, enable and characters out
	bringup_sequencer u_sequencer (
		.clk27m			( clk27m		),
		.ff_reset_n		( ff_reset_n	),
		.dipsw			( dipsw			),
		.send_busy		( w_send_busy	),
		.send_req		( w_send_req	),
		.send_data		( w_send_data	),
		.exercise_en	( w_exercise_en	)
	);

	video_pattern_gen u_video (
		.clk27m			( clk27m		),
		.ff_reset_n		( ff_reset_n	),
		.exercise_en	( w_exercise_en	),
		.video_hs		( p_video_hs	),
		.video_vs		( p_video_vs	),
		.video_r		( p_video_r		),
		.video_g		( p_video_g		),
		.video_b		( p_video_b		)
	);

	slot_pin_exerciser u_slot (
		.clk27m			( clk27m		),
		.ff_reset_n		( ff_reset_n	),
		.exercise_en	( w_exercise_en	),
		.slot_data		( p_slot_data	),
		.slot_wait		( p_slot_wait	),
		.slot_int		( p_slot_int	)
	);

	// 115200 baud from the board oscillator
	uart_tx #(
		.clk_div		( `BRINGUP_UART_DIV	)
	) u_uart (
		.clk27m			( clk27m		),
		.ff_reset_n		( ff_reset_n	),
		.send_data		( w_send_data	),
		.send_req		( w_send_req	),
		.send_busy		( w_send_busy	),
		.uart_tx		( uart_tx		)
	);

	// level shifter points toward the slot and stays enabled
	assign p_slot_data_dir = 1'b0;
	assign p_slot_oe_n = 1'b0;

endmodule

//--- rtl/uart_tx.sv
// 8n1 serial transmitter with a fixed clock divisor

`timescale 1ns/1ps

module uart_tx #(
	parameter int clk_div = 234
) (
	input	logic						clk27m,
	input	logic						ff_reset_n,
	input	bringup_pkg::uart_byte_t	send_data,
	input	logic						send_req,
	output	logic						send_busy,
	output	logic						uart_tx
);
	localparam int cnt_w = $clog2(clk_div);

	typedef logic [cnt_w-1:0] bit_cnt_t;

	localparam bit_cnt_t cnt_last = bit_cnt_t'(clk_div - 1);

	bit_cnt_t		ff_cnt;
	logic [3:0]		ff_bit_idx;
	logic [9:0]		ff_shift;
	logic			ff_busy;
	logic			w_bit_end;

	// ------------------------------------------------------------------------
	//	bit timing
	// ------------------------------------------------------------------------

	assign w_bit_end = (ff_cnt == cnt_last);

	always_ff @(posedge clk27m) begin
		if (!ff_reset_n) begin
			ff_cnt <= '0;
		end
		else if (!ff_busy || w_bit_end) begin
			// restarts with every frame
			ff_cnt <= '0;
		end
		else begin
			ff_cnt <= ff_cnt + 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	//	frame shifter
	// ------------------------------------------------------------------------

	// frame is {stop, d7..d0, start}, shifted out lsb first
	// shifter fills with ones so the line idles high
	always_ff @(posedge clk27m) begin
		if (!ff_reset_n) begin
			ff_shift <= 10'h3ff;
			ff_bit_idx <= 4'd0;
			ff_busy <= 1'b0;
		end
		else if (!ff_busy) begin
			if (send_req) begin
				ff_shift <= {1'b1, send_data, 1'b0};
				ff_bit_idx <= 4'd0;
				ff_busy <= 1'b1;
			end
		end
		else if (w_bit_end) begin
			ff_shift <= {1'b1, ff_shift[9:1]};
			if (ff_bit_idx == 4'd9) begin
				// end of stop bit
				ff_busy <= 1'b0;
				ff_bit_idx <= 4'd0;
			end
			else begin
				ff_bit_idx <= ff_bit_idx + 4'd1;
			end
		end
	end

	assign send_busy = ff_busy;
	assign uart_tx = ff_shift[0];

	// a low line is always part of a frame in flight
	a_low_while_busy: assert property (@(posedge clk27m) disable iff (!ff_reset_n)
		!uart_tx |-> send_busy);

endmodule

//--- rtl/video_pattern_gen.sv
// sync toggles and colour ramp counters for the video pins

`timescale 1ns/1ps

`include "bringup_params.svh"

module video_pattern_gen (
	input	logic					clk27m,
	input	logic					ff_reset_n,
	input	logic					exercise_en,
	output	logic					video_hs,
	output	logic					video_vs,
	output	bringup_pkg::colour_t	video_r,
	output	bringup_pkg::colour_t	video_g,
	output	bringup_pkg::colour_t	video_b
);
	logic					ff_video_hs;
	logic					ff_video_vs;
	bringup_pkg::colour_t	ff_video_r;
	bringup_pkg::colour_t	ff_video_g;
	bringup_pkg::colour_t	ff_video_b;

	// ------------------------------------------------------------------------
	//	sync lines
	// ------------------------------------------------------------------------

	// no real timing, both just flip every enabled clock
	always_ff @(posedge clk27m) begin
		if (!ff_reset_n) begin
			ff_video_hs <= 1'b0;
			ff_video_vs <= 1'b0;
		end
		else if (exercise_en) begin
			ff_video_hs <= ~ff_video_hs;
			ff_video_vs <= ~ff_video_vs;
		end
	end

	// ------------------------------------------------------------------------
	//	colour ramps
	// ------------------------------------------------------------------------

	// odd steps so every value of every channel is visited
	// wrap at 32 is natural for 5 bits
	always_ff @(posedge clk27m) begin
		if (!ff_reset_n) begin
			ff_video_r <= 5'd0;
			ff_video_g <= 5'd0;
			ff_video_b <= 5'd0;
		end
		else if (exercise_en) begin
			ff_video_r <= ff_video_r + `BRINGUP_STEP_R;
			ff_video_g <= ff_video_g + `BRINGUP_STEP_G;
			ff_video_b <= ff_video_b + `BRINGUP_STEP_B;
		end
	end

	// outputs straight from the flops
	assign video_hs = ff_video_hs;
	assign video_vs = ff_video_vs;
	assign video_r = ff_video_r;
	assign video_g = ff_video_g;
	assign video_b = ff_video_b;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# compile the bring-up testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_bringup \
	-f verilog.f -o tb_bringup

sim_output="$(./obj_dir/tb_bringup)"
echo "$sim_output"

if grep -q "Test completed successfully" <<< "$sim_output"; then
	exit 0
fi
exit 1

//--- verification/tb_bringup_checks.svh
// result counters, reference functions, lfsr, serial receiver and compare tasks

`ifndef TB_BRINGUP_CHECKS_SVH
`define TB_BRINGUP_CHECKS_SVH

// ----------------------------------------------------------------------------
//	bookkeeping
// ----------------------------------------------------------------------------

string			current_test;
int				test_errors;
int				total_errors;
int				tests_passed;
int				tests_failed;
logic [31:0]	lfsr_state;

task automatic start_test(input string name);
	current_test = name;
	test_errors = 0;
endtask

task automatic end_test();
	if (test_errors == 0) begin
		tests_passed++;
		$display("%s: passed", current_test);
	end
	else begin
		tests_failed++;
		$display("%s: %0d errors", current_test, test_errors);
	end
endtask

task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
	if (exp !== act) begin
		$display("Mismatch %s %s: expected %0h, actual %0h", current_test, what, exp, act);
		test_errors++;
		total_errors++;
	end
endtask

// ----------------------------------------------------------------------------
//	reference model
// ----------------------------------------------------------------------------

// exercise pins packed as {hs, vs, wait, int, r, g, b, data}
function automatic logic [26:0] pins_now();
	return {p_video_hs, p_video_vs, p_slot_wait, p_slot_int,
		p_video_r, p_video_g, p_video_b, p_slot_data};
endfunction

// one enabled clock later, colours wrap at 32 and data at 256
function automatic logic [26:0] expected_step(input logic [26:0] prev);
	logic [3:0]					toggles;
	bringup_pkg::colour_t		r;
	bringup_pkg::colour_t		g;
	bringup_pkg::colour_t		b;
	bringup_pkg::slot_data_t	d;
	toggles = ~prev[26:23];
	r = prev[22:18] + `BRINGUP_STEP_R;
	g = prev[17:13] + `BRINGUP_STEP_G;
	b = prev[12:8] + `BRINGUP_STEP_B;
	d = prev[7:0] + 8'd1;
	return {toggles, r, g, b, d};
endfunction

function automatic bringup_pkg::uart_byte_t expected_char(input logic [3:0] nibble);
	return `BRINGUP_CHAR_BASE + {4'd0, nibble};
endfunction

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic draw_nibble(output logic [3:0] nibble);
	int		k;
	for (k = 0; k < 4; k++) begin
		lfsr_state = lfsr_next(lfsr_state);
		nibble[k] = lfsr_state[0];
	end
endtask

// ----------------------------------------------------------------------------
//	serial receiver
// ----------------------------------------------------------------------------

// start edge found on a falling clock, then sampled at bit centres
task automatic receive_frame(output bringup_pkg::uart_byte_t data, output logic stop,
		output time start);
	int		waited;
	int		b;
	waited = 0;
	data = '0;
	stop = 1'b0;
	start = 0;
	@(negedge clk27m);
	while (uart_tx !== 1'b0 && waited < 12 * `BRINGUP_UART_DIV) begin
		@(negedge clk27m);
		waited++;
	end
	if (uart_tx !== 1'b0) begin
		$display("%s: no start bit on the serial line within 12 bit times", current_test);
		test_errors++;
	end
	else begin
		start = $time;
		repeat (`BRINGUP_UART_DIV / 2) @(negedge clk27m);
		check_value("start bit", 0, uart_tx);
		for (b = 0; b < 8; b++) begin
			repeat (`BRINGUP_UART_DIV) @(negedge clk27m);
			data[b] = uart_tx;
		end
		repeat (`BRINGUP_UART_DIV) @(negedge clk27m);
		stop = uart_tx;
	end
endtask

`endif

//--- verification/tb_bringup.sv
// testbench top with clock, reset, stimulus, dut instance and test sequence

`timescale 1ns/1ps

`include "bringup_params.svh"

module tb_bringup;
	localparam int	clk_period_ns = 8;
	localparam time	bit_ns = `BRINGUP_UART_DIV * clk_period_ns;

	logic						clk27m;
	logic						ff_reset_n;
	bringup_pkg::dipsw_t		dipsw;
	bringup_pkg::slot_data_t	p_slot_data;
	logic						p_slot_data_dir;
	logic						p_slot_oe_n;
	logic						p_slot_int;
	logic						p_slot_wait;
	logic						p_video_hs;
	logic						p_video_vs;
	bringup_pkg::colour_t		p_video_r;
	bringup_pkg::colour_t		p_video_g;
	bringup_pkg::colour_t		p_video_b;
	logic						uart_tx;

	`include "tb_bringup_checks.svh"

	initial begin
		clk27m = 1'b0;
		forever begin
			#(clk_period_ns / 2) clk27m = ~clk27m;
		end
	end

	// slot inputs parked at their idle levels
	tangprimer20k_vdp_cartridge_test i_tangprimer20k_vdp_cartridge_test (
		.clk27m(clk27m), .ff_reset_n(ff_reset_n), .dipsw(dipsw),
		.p_slot_reset_n(1'b1), .p_slot_sltsl_n(1'b1), .p_slot_mreq_n(1'b1),
		.p_slot_ioreq_n(1'b1), .p_slot_wr_n(1'b1), .p_slot_rd_n(1'b1),
		.p_slot_m1_n(1'b1), .p_slot_rfsh_n(1'b1), .p_slot_address(16'h0000),
		.p_slot_data(p_slot_data), .p_slot_data_dir(p_slot_data_dir),
		.p_slot_oe_n(p_slot_oe_n), .p_slot_int(p_slot_int), .p_slot_wait(p_slot_wait),
		.p_video_hs(p_video_hs), .p_video_vs(p_video_vs), .p_video_r(p_video_r),
		.p_video_g(p_video_g), .p_video_b(p_video_b), .uart_tx(uart_tx)
	);

	// ------------------------------------------------------------------------
	//	stimulus and pin checks
	// ------------------------------------------------------------------------

	task automatic drive_dipsw(input bringup_pkg::dipsw_t value);
		@(posedge clk27m);
		#1;
		dipsw = value;
	endtask

	// 8 clocks low with pins sampled 1 ns after each edge
	task automatic reset_and_check(input string name);
		int		n;
		start_test(name);
		if (ff_reset_n) begin
			@(posedge clk27m);
			#1;
			ff_reset_n = 1'b0;
		end
		for (n = 0; n < 8; n++) begin
			@(posedge clk27m);
			#1;
			check_value("pins", 0, pins_now());
			check_value("uart_tx", 1, uart_tx);
			check_value("dir and oe_n", 0, {p_slot_data_dir, p_slot_oe_n});
		end
		ff_reset_n = 1'b1;
		end_test();
	endtask

	// first cycle where red has moved
	task automatic wait_ramp_start();
		bringup_pkg::colour_t	start_r;
		int						waited;
		start_r = p_video_r;
		waited = 0;
		@(negedge clk27m);
		while (p_video_r == start_r && waited < 16) begin
			@(negedge clk27m);
			waited++;
		end
		if (p_video_r == start_r) begin
			$display("%s: colour ramp did not start within 16 cycles", current_test);
			test_errors++;
		end
	endtask

	task automatic check_ramp(input int cycles);
		logic [26:0]	prev;
		int				n;
		prev = pins_now();
		for (n = 0; n < cycles; n++) begin
			@(negedge clk27m);
			check_value("ramp", expected_step(prev), pins_now());
			prev = pins_now();
		end
	endtask

	// reference taken mid cycle, away from the edge
	task automatic check_frozen(input int cycles);
		logic [26:0]	held;
		int				n;
		@(negedge clk27m);
		held = pins_now();
		for (n = 0; n < cycles; n++) begin
			@(negedge clk27m);
			check_value("frozen", held, pins_now());
		end
	endtask

	// ------------------------------------------------------------------------
	//	test sequence
	// ------------------------------------------------------------------------

	initial begin
		logic [3:0]					nibble;
		bringup_pkg::uart_byte_t	rx_data;
		logic						rx_stop;
		time						rx_start;
		time						prev_start;
		int							i;
		ff_reset_n = 1'b0;
		dipsw = 5'd0;
		total_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		lfsr_state = 32'ha306a03f;
		nibble = 4'd0;
		reset_and_check("reset_values");
		start_test("pin_ramp");
		wait_ramp_start();
		check_ramp(200);
		end_test();
		// enable drops 2 clocks after the switch so 4 leave some margin
		start_test("freeze");
		drive_dipsw(5'b1_0000);
		repeat (4) @(posedge clk27m);
		check_frozen(100);
		drive_dipsw(5'b0_0000);
		wait_ramp_start();
		check_ramp(100);
		end_test();
		// fresh reset so the receiver starts on an idle line
		reset_and_check("reset_before_serial");
		start_test("character");
		for (i = 0; i < 4; i++) begin
			draw_nibble(nibble);
			drive_dipsw({1'b0, nibble});
			receive_frame(rx_data, rx_stop, rx_start);
			receive_frame(rx_data, rx_stop, rx_start);
			check_value("data", expected_char(nibble), rx_data);
			check_value("stop bit", 1, rx_stop);
		end
		end_test();
		start_test("continuous_send");
		receive_frame(rx_data, rx_stop, prev_start);
		check_value("data", expected_char(nibble), rx_data);
		for (i = 0; i < 2; i++) begin
			receive_frame(rx_data, rx_stop, rx_start);
			check_value("data", expected_char(nibble), rx_data);
			if (rx_start < prev_start || rx_start - prev_start > 12 * bit_ns) begin
				$display("%s: start edges more than 12 bit times apart", current_test);
				test_errors++;
			end
			prev_start = rx_start;
		end
		end_test();
		$display("passed tests %0d, failed tests %0d, mismatches %0d",
			tests_passed, tests_failed, total_errors);
		if (tests_failed == 0) begin
			$display("Test completed successfully");
		end
		else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+rtl
+incdir+verification
rtl/bringup_pkg.sv
rtl/bringup_sequencer.sv
rtl/video_pattern_gen.sv
rtl/slot_pin_exerciser.sv
rtl/uart_tx.sv
rtl/tangprimer20k_vdp_cartridge_test.sv
verification/tb_bringup.sv
